// File: common/crank_params.svh
`ifndef CRANK_PARAMS_SVH
`define CRANK_PARAMS_SVH

// Width of one period measured in clk cycles
`define CRANK_PERIOD_WIDTH 16

// Trigger wheel geometry
`define CRANK_TEETH   60
`define CRANK_MISSING 2

// Register word address
`define CRANK_ADDR_WIDTH 3

// Limit register values out of reset
`define CRANK_MIN_RESET 8
`define CRANK_MAX_RESET 16'hFFFF

`endif

// File: common/crank_pkg.sv
`include "crank_params.svh"

package crank_pkg;

	// Clock cycles between two tooth edges
	typedef logic [`CRANK_PERIOD_WIDTH-1:0] period_t;

	typedef logic [$clog2(`CRANK_TEETH)-1:0] tooth_t; // Tooth index within a revolution

	typedef logic [15:0] rev_t; // Revolutions since sync

	typedef struct packed {
		logic    valid; // One cycle per detected edge
		period_t cap0;  // Newest period
		period_t cap1;
		period_t cap2;  // Oldest period
	} capture_t;

	typedef struct packed {
		logic valid;
		logic period_ok; // Inside the min and max window
		logic gap;       // Long period between two short ones
		logic stall;     // Wheel slower than twice the last period
	} check_t;

	// Gap seen once, then confirmed one revolution later
	typedef enum logic [1:0] {
		SEARCH = 2'd0,
		VERIFY = 2'd1,
		SYNCED = 2'd2
	} sync_state_t;

endpackage

// File: common/crank_bus_pkg.sv
`include "crank_params.svh"

package crank_bus_pkg;

	typedef logic [`CRANK_ADDR_WIDTH-1:0] wb_addr_t; // Word address
	typedef logic [31:0]                  wb_data_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	typedef enum logic [`CRANK_ADDR_WIDTH-1:0] {
		CTRL   = 0, // Bit 0 enables the decoder
		MIN    = 1,
		MAX    = 2,
		STATUS = 3, // Read only
		REVS   = 4, // Read only
		LAST   = 5  // Newest captured period
	} reg_addr_t;

endpackage

// File: source/edge_capture.sv
`timescale 1ns/100ps

module edge_capture (
	input  logic                clk,
	input  logic                rst,
	input  logic                enable,
	input  logic                tooth,
	output crank_pkg::capture_t cap,
	output crank_pkg::period_t  pcnt
);
	import crank_pkg::*;

	localparam period_t PERIOD_MAX = '1;

	logic [1:0] sync_q; // Two-flop synchronizer
	logic       last_q;
	logic       rise;

	assign rise = enable & sync_q[1] & ~last_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '0;
			last_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], tooth};
			last_q <= sync_q[1];
		end
	end

	// Period counter and three-deep history
	always_ff @(posedge clk) begin
		if (rst) begin
			pcnt <= '0;
			cap  <= '0;
		end else begin
			cap.valid <= rise;
			if (rise) begin
				cap.cap2 <= cap.cap1;
				cap.cap1 <= cap.cap0;
				cap.cap0 <= pcnt;
				pcnt     <= period_t'(1); // Edge cycle counts as the first
			end else if (pcnt != PERIOD_MAX) begin
				pcnt <= pcnt + 1'b1; // Saturates when the wheel stops
			end
		end
	end

	// Synchronized edges are at least two cycles apart
	cap_valid_pulse: assert property (
		@(posedge clk) disable iff (rst)
		cap.valid |=> !cap.valid
	);

endmodule

// File: crank_sync/period_checks.sv
`timescale 1ns/100ps

module period_checks (
	input  logic                clk,
	input  logic                rst,
	input  crank_pkg::capture_t cap,
	input  crank_pkg::period_t  pcnt,
	input  crank_pkg::period_t  min_period,
	input  crank_pkg::period_t  max_period,
	output crank_pkg::check_t   chk
);
	import crank_pkg::*;

	localparam int W = $bits(period_t);

	period_t half_cap1;
	period_t double_cap0;
	logic    less_max;
	logic    more_min;
	logic    gap_found;
	logic    gap_run;

	assign half_cap1   = {1'b0, cap.cap1[W-1:1]};
	assign double_cap0 = {cap.cap0[W-2:0], 1'b0};

	// Fails only on two long periods in a row
	assign less_max = (cap.cap0 < max_period) || (cap.cap1 < max_period);

	assign more_min = (cap.cap0 > min_period) &&
	                  (cap.cap1 > min_period) &&
	                  (cap.cap2 > min_period);

	assign gap_found = (cap.cap0 < half_cap1) && (cap.cap2 < half_cap1);

	// Running count already past any gap
	assign gap_run = (double_cap0 < pcnt) || (pcnt == '1);

	always_ff @(posedge clk) begin
		if (rst) begin
			chk <= '0;
		end else begin
			chk.valid     <= cap.valid;
			chk.period_ok <= cap.valid & less_max & more_min;
			chk.gap       <= cap.valid & gap_found;
			chk.stall     <= gap_run; // Watched between edges
		end
	end

	// Results only appear on the cycle after a capture
	chk_on_capture: assert property (
		@(posedge clk) disable iff (rst)
		(chk.gap || chk.period_ok) |-> chk.valid && $past(cap.valid)
	);

endmodule

// File: crank_sync/sync_tracker.sv
`timescale 1ns/100ps
`include "crank_params.svh"

module sync_tracker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   enable,
	input  crank_pkg::check_t      chk,
	output crank_pkg::sync_state_t state,
	output crank_pkg::tooth_t      tooth,
	output crank_pkg::rev_t        revs
);
	import crank_pkg::*;

	// Last tooth before the missing ones
	localparam tooth_t LAST_TOOTH = tooth_t'(`CRANK_TEETH - `CRANK_MISSING - 1);

	// Tooth 0 ends the long period, tooth 1 is where the gap shows
	localparam tooth_t GAP_TOOTH = '0;

	logic gap_due;
	logic lose_sync;

	assign gap_due = (tooth == GAP_TOOTH);

	always_comb begin
		if (chk.valid) begin
			lose_sync = !chk.period_ok || (chk.gap != gap_due);
		end else begin
			lose_sync = chk.stall && (tooth != LAST_TOOTH); // Gap itself looks like a stall
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEARCH;
			tooth <= '0;
			revs  <= '0;
		end else if (!enable) begin
			state <= SEARCH;
			tooth <= '0;
		end else begin
			case (state)
				SEARCH: begin
					if (chk.valid && chk.gap && chk.period_ok) begin
						state <= VERIFY;
						tooth <= tooth_t'(1);
					end
				end
				default: begin
					if (lose_sync) begin
						state <= SEARCH;
						tooth <= '0;
					end else if (chk.valid) begin
						if (chk.gap) begin // Confirmed one revolution on
							state <= SYNCED;
							revs  <= revs + 1'b1;
							tooth <= tooth_t'(1);
						end else if (tooth == LAST_TOOTH) begin
							tooth <= GAP_TOOTH;
						end else begin
							tooth <= tooth + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// SYNCED is only ever reached through VERIFY
	synced_tooth_range: assert property (
		@(posedge clk) disable iff (rst)
		state == SYNCED |-> tooth <= LAST_TOOTH && $past(state) != SEARCH
	);

endmodule

// File: source/crank_regs.sv
`timescale 1ns/100ps
`include "crank_params.svh"

module crank_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  crank_bus_pkg::wb_req_t wb_req,
	output crank_bus_pkg::wb_rsp_t wb_rsp,
	output logic                   enable,
	output crank_pkg::period_t     min_period,
	output crank_pkg::period_t     max_period,
	input  crank_pkg::sync_state_t state,
	input  crank_pkg::tooth_t      tooth,
	input  crank_pkg::rev_t        revs,
	input  crank_pkg::period_t     last_period
);
	import crank_pkg::*;
	import crank_bus_pkg::*;

	logic     ack_q;
	logic     access;
	wb_data_t rdata;
	wb_data_t dat_q;

	assign access = wb_req.cyc & wb_req.stb & ~ack_q; // New request this cycle
	assign wb_rsp = '{ack: ack_q, dat: dat_q};

	always_comb begin
		rdata = '0; // Unused addresses read zero
		case (reg_addr_t'(wb_req.adr))
			CTRL:   rdata[0] = enable;
			MIN:    rdata = wb_data_t'(min_period);
			MAX:    rdata = wb_data_t'(max_period);
			STATUS: begin
				rdata[1:0]  = state;
				rdata[13:8] = tooth;
			end
			REVS:   rdata = wb_data_t'(revs);
			LAST:   rdata = wb_data_t'(last_period);
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q      <= 1'b0;
			enable     <= 1'b0;
			min_period <= period_t'(`CRANK_MIN_RESET);
			max_period <= period_t'(`CRANK_MAX_RESET);
		end else begin
			ack_q <= access;
			if (access && wb_req.we) begin
				case (reg_addr_t'(wb_req.adr))
					CTRL:    enable <= wb_req.dat[0];
					MIN:     min_period <= period_t'(wb_req.dat);
					MAX:     max_period <= period_t'(wb_req.dat);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			dat_q <= rdata;
		end
	end

	// One ack per request and never two in a row
	single_ack: assert property (
		@(posedge clk) disable iff (rst)
		ack_q |-> $past(wb_req.cyc && wb_req.stb) ##1 !ack_q
	);

endmodule

// File: source/crank_decoder_top.sv
`timescale 1ns/100ps

module crank_decoder_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   tooth,
	input  crank_bus_pkg::wb_req_t wb_req,
	output crank_bus_pkg::wb_rsp_t wb_rsp
);
	import crank_pkg::*;

	capture_t    cap;
	period_t     pcnt;
	period_t     min_period;
	period_t     max_period;
	check_t      chk;
	sync_state_t state;
	tooth_t      tooth_idx; // Position on the wheel
	rev_t        revs;
	logic        enable;

	edge_capture edge_capture_i (
		.clk    (clk),
		.rst    (rst),
		.enable (enable),
		.tooth  (tooth),
		.cap    (cap),
		.pcnt   (pcnt)
	);

	period_checks period_checks_i (
		.clk        (clk),
		.rst        (rst),
		.cap        (cap),
		.pcnt       (pcnt),
		.min_period (min_period),
		.max_period (max_period),
		.chk        (chk)
	);

	sync_tracker sync_tracker_i (
		.clk    (clk),
		.rst    (rst),
		.enable (enable),
		.chk    (chk),
		.state  (state),
		.tooth  (tooth_idx),
		.revs   (revs)
	);

	crank_regs crank_regs_i (
		.clk         (clk),
		.rst         (rst),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.enable      (enable),
		.min_period  (min_period),
		.max_period  (max_period),
		.state       (state),
		.tooth       (tooth_idx),
		.revs        (revs),
		.last_period (cap.cap0)
	);

endmodule

// File: bench/crank_decoder_tb.sv
`timescale 1ns/100ps
`include "crank_params.svh"

module crank_decoder_tb;
	import crank_pkg::*;
	import crank_bus_pkg::*;

	localparam int CLK_PERIOD    = 20;
	localparam int DRIVE_DELAY   = 2;
	localparam int RESET_CYCLES  = 16;
	localparam int ACK_TIMEOUT   = 50;
	localparam int WHEEL_P       = 40; // Nominal tooth period in cycles
	localparam int REV           = `CRANK_TEETH;
	localparam int FIRST_MISSING = `CRANK_TEETH - `CRANK_MISSING;
	localparam int BASE_MIN      = `CRANK_MIN_RESET;

	typedef struct packed {
		period_t     period;
		logic [15:0] positions;
		logic        gap;     // Missing teeth present on the wheel
		logic        stopped;
		logic        enable;
		period_t     min_period;
		sync_state_t exp_state;
		rev_t        exp_revs;
		tooth_t      exp_tooth;
	} row_t;

	logic    clk;
	logic    rst;
	logic    tooth;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	row_t        rows[$];
	int          wheel_pos;      // Position of the next tooth slot
	time         last_rise;
	int unsigned applied_period; // Cycles between the last two driven edges
	int unsigned watchdog_cycles;

	crank_decoder_top dut_i (
		.clk    (clk),
		.rst    (rst),
		.tooth  (tooth),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic end_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			end_with_failure();
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic bus_access(input reg_addr_t addr, input logic we,
			input wb_data_t wdata, output wb_data_t rdata);
		int waited;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdata};
		waited = 0;
		wait_cycles(1);
		while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
			wait_cycles(1);
			waited++;
		end
		if (!wb_rsp.ack) begin
			$display("No Wishbone acknowledge from address %0d within %0d cycles",
				addr, ACK_TIMEOUT);
			end_with_failure();
		end else begin
			rdata  = wb_rsp.dat; // Valid while ack is high
			wb_req = '0;
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input wb_data_t wdata);
		wb_data_t unused;
		bus_access(addr, 1'b1, wdata, unused);
	endtask

	task automatic read_reg(input reg_addr_t addr, output wb_data_t rdata);
		bus_access(addr, 1'b0, '0, rdata);
	endtask

	task automatic drive_position(input int len, input bit has_tooth);
		if (has_tooth) begin
			tooth          = 1'b1;
			applied_period = int'(($time - last_rise) / CLK_PERIOD);
			last_rise      = $time;
		end
		wait_cycles(len / 2);
		tooth = 1'b0;
		wait_cycles(len - len / 2);
	endtask

	// Wheel model, one slot per tooth position
	task automatic play_row(input row_t row);
		int len;
		bit has_tooth;
		for (int i = 0; i < int'(row.positions); i++) begin
			if (row.stopped) begin
				drive_position(int'(row.period), 1'b0); // Wheel at rest
			end else begin
				len       = int'(row.period) + int'($urandom % 3) - 1;
				has_tooth = !row.gap || (wheel_pos < FIRST_MISSING);
				drive_position(len, has_tooth);
				wheel_pos = (wheel_pos + 1) % REV;
			end
		end
	endtask

	task automatic add_row(input int period, input int positions, input bit gap,
			input bit stopped, input bit enable, input int min_period,
			input sync_state_t exp_state, input int exp_revs, input int exp_tooth);
		row_t row;
		row.period     = period_t'(period);
		row.positions  = 16'(positions);
		row.gap        = gap;
		row.stopped    = stopped;
		row.enable     = enable;
		row.min_period = period_t'(min_period);
		row.exp_state  = exp_state;
		row.exp_revs   = rev_t'(exp_revs);
		row.exp_tooth  = tooth_t'(exp_tooth);
		rows.push_back(row);
	endtask

	task automatic build_table();
		// Period, slots, gap, stopped, enable, MIN, then state, revs, tooth
		add_row(WHEEL_P, REV + 2, 1, 0, 1, BASE_MIN, VERIFY, 0, 1); // First gap
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, SYNCED, 1, 1);
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, SYNCED, 2, 1);
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, SYNCED, 3, 1);
		add_row(WHEEL_P, REV, 0, 0, 1, BASE_MIN, SEARCH, 3, 0); // Gap filled in
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, VERIFY, 3, 1);
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, SYNCED, 4, 1);
		add_row(WHEEL_P, 4, 1, 1, 1, BASE_MIN, SEARCH, 4, 0); // Wheel stopped
		add_row(WHEEL_P, 2 * REV, 1, 0, 1, 50, SEARCH, 4, 0); // MIN above period
		add_row(WHEEL_P, 2 * REV, 1, 0, 0, BASE_MIN, SEARCH, 4, 0);
		add_row(WHEEL_P, REV, 1, 0, 1, BASE_MIN, VERIFY, 4, 1); // Enabled again
	endtask

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clock cycles",
			watchdog_cycles);
		end_with_failure();
	end

	initial begin : main_sequence
		wb_data_t data;
		void'($urandom(60543));
		clk            = 1'b0;
		rst            = 1'b1;
		tooth          = 1'b0;
		wb_req         = '0;
		wheel_pos      = 0;
		last_rise      = 0;
		applied_period = 0;
		build_table();
		watchdog_cycles = RESET_CYCLES + 2000; // Reset and bus traffic
		foreach (rows[r]) begin
			watchdog_cycles += (int'(rows[r].period) + 1) * int'(rows[r].positions);
		end
		wait_cycles(RESET_CYCLES);
		rst = 1'b0;

		// Register values out of reset
		read_reg(CTRL, data);
		check_value("CTRL", data, 32'd0);
		read_reg(MIN, data);
		check_value("MIN", data, 32'd8);
		read_reg(MAX, data);
		check_value("MAX", data, 32'h0000_ffff);
		read_reg(STATUS, data);
		check_value("STATUS", data, 32'd0); // SEARCH at tooth 0
		read_reg(REVS, data);
		check_value("REVS", data, 32'd0);
		write_reg(MIN, 32'd20);
		write_reg(MAX, 32'd1000);
		read_reg(MIN, data);
		check_value("MIN", data, 32'd20);
		read_reg(MAX, data);
		check_value("MAX", data, 32'd1000);

		foreach (rows[r]) begin
			write_reg(CTRL, wb_data_t'(rows[r].enable));
			read_reg(CTRL, data);
			check_value($sformatf("enable in row %0d", r), data,
				wb_data_t'(rows[r].enable));
			write_reg(MIN, wb_data_t'(rows[r].min_period));
			play_row(rows[r]);
			read_reg(STATUS, data);
			check_value($sformatf("state in row %0d", r), wb_data_t'(data[1:0]),
				wb_data_t'(rows[r].exp_state));
			check_value($sformatf("tooth in row %0d", r), wb_data_t'(data[13:8]),
				wb_data_t'(rows[r].exp_tooth));
			read_reg(REVS, data);
			check_value($sformatf("revs in row %0d", r), data,
				wb_data_t'(rows[r].exp_revs));
			if (rows[r].enable) begin
				read_reg(LAST, data); // Edges are only captured while enabled
				check_value($sformatf("last period in row %0d", r), data,
					wb_data_t'(applied_period));
			end
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+common
common/crank_pkg.sv
common/crank_bus_pkg.sv
source/edge_capture.sv
crank_sync/period_checks.sv
crank_sync/sync_tracker.sv
source/crank_regs.sv
source/crank_decoder_top.sv
bench/crank_decoder_tb.sv

// File: Bender.yml
package:
  name: crank_decoder

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/crank_pkg.sv
      - common/crank_bus_pkg.sv
      - source/edge_capture.sv
      - crank_sync/period_checks.sv
      - crank_sync/sync_tracker.sv
      - source/crank_regs.sv
      - source/crank_decoder_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/crank_decoder_tb.sv
